//--- start_pkg.sv
package start_pkg;

  // word address on the memory bus
  typedef logic [15:0] addr_t;

  // one memory word
  // holds commands and pointer values
  typedef logic [31:0] data_t;

  // instruction pointer register offset from base_addr
  localparam addr_t REG_IP = 16'd4;

  // words in word_memory
  // addresses wrap modulo this depth
  localparam int MEM_DEPTH = 256;

  // fetch sequencer states
  typedef enum logic [2:0] {
    // waiting for start
    idle,
    // reading the pointer register
    read_ip,
    // reading the command at the pointer
    read_cmd,
    // writing back pointer + 1
    write_ip,
    // one cycle of done
    finish
  } start_state_t;

endpackage

//--- bus_if.sv
`timescale 1ns/100ps

// one request/response channel between a bus master and a slave
interface bus_if;

  start_pkg::addr_t addr;
  start_pkg::data_t wdata;
  start_pkg::data_t rdata;

  // request levels, held until the matching done pulse
  logic read_q;
  logic write_q;

  // one-cycle done pulses from the slave
  logic read_dn;
  logic write_dn;

  modport master (
    output addr, wdata, read_q, write_q,
    input  rdata, read_dn, write_dn
  );

  modport slave (
    input  addr, wdata, read_q, write_q,
    output rdata, read_dn, write_dn
  );

endinterface

//--- start_manager.sv
`timescale 1ns/100ps

module start_manager (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  logic             disp_online,
  input  start_pkg::addr_t base_addr,
  bus_if.master            bus,
  output start_pkg::data_t command,
  output start_pkg::addr_t cmd_ptr,
  output logic             done
);

  start_pkg::start_state_t state;

  // pointer register address in memory
  start_pkg::addr_t ip_addr;

  logic read_q;
  logic write_q;

  assign ip_addr = base_addr + start_pkg::REG_IP;

  // command read goes to the pointer
  // pointer read and write-back go to the register
  assign bus.addr = (state == start_pkg::read_cmd) ? cmd_ptr : ip_addr;

  // write-back value holds the already incremented pointer
  assign bus.wdata = start_pkg::data_t'(cmd_ptr);

  assign bus.read_q  = read_q;
  assign bus.write_q = write_q;

  // done lasts exactly the finish state
  assign done = (state == start_pkg::finish);

  // sequencer
  // a raised request stays up even if the dispatcher goes offline
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= start_pkg::idle;
      read_q  <= 1'b0;
      write_q <= 1'b0;
    end else begin
      case (state)
        start_pkg::idle: begin
          // start outside idle is ignored
          if (start) begin
            state <= start_pkg::read_ip;
          end
        end
        start_pkg::read_ip: begin
          if (bus.read_dn) begin
            read_q <= 1'b0;
            state  <= start_pkg::read_cmd;
          end else if (disp_online) begin
            read_q <= 1'b1;
          end
        end
        start_pkg::read_cmd: begin
          if (bus.read_dn) begin
            read_q <= 1'b0;
            state  <= start_pkg::write_ip;
          end else if (disp_online) begin
            read_q <= 1'b1;
          end
        end
        start_pkg::write_ip: begin
          if (bus.write_dn) begin
            write_q <= 1'b0;
            state   <= start_pkg::finish;
          end else if (disp_online) begin
            write_q <= 1'b1;
          end
        end
        start_pkg::finish: begin
          state <= start_pkg::idle;
        end
        default: begin
          state   <= start_pkg::idle;
          read_q  <= 1'b0;
          write_q <= 1'b0;
        end
      endcase
    end
  end

  // fetched values
  // held from done until the next sequence overwrites them
  always_ff @(posedge clk) begin
    if (state == start_pkg::read_ip && bus.read_dn) begin
      // pointer lives in the low bits of the register word
      cmd_ptr <= start_pkg::addr_t'(bus.rdata);
    end
    if (state == start_pkg::read_cmd && bus.read_dn) begin
      command <= bus.rdata;
      cmd_ptr <= cmd_ptr + start_pkg::addr_t'(1);
    end
  end

endmodule

//--- load_port.sv
`timescale 1ns/100ps

module load_port (
  input  logic             clk,
  input  logic             rst,
  input  logic             load_we,
  input  start_pkg::addr_t load_addr,
  input  start_pkg::data_t load_data,
  output logic             load_ready,
  bus_if.master            bus
);

  start_pkg::addr_t addr_r;
  start_pkg::data_t data_r;
  logic             write_q;

  // write-only master
  assign bus.read_q  = 1'b0;
  assign bus.write_q = write_q;
  assign bus.addr    = addr_r;
  assign bus.wdata   = data_r;

  // ready whenever no write is pending
  assign load_ready = ~write_q;

  // pending write flag
  // held through arbitration until the memory answers
  always_ff @(posedge clk) begin
    if (rst) begin
      write_q <= 1'b0;
    end else if (bus.write_dn) begin
      write_q <= 1'b0;
    end else if (load_we && load_ready) begin
      write_q <= 1'b1;
    end
  end

  // strobe payload
  always_ff @(posedge clk) begin
    if (load_we && load_ready) begin
      addr_r <= load_addr;
      data_r <= load_data;
    end
  end

endmodule

//--- bus_arbiter.sv
`timescale 1ns/100ps

module bus_arbiter (
  input  logic clk,
  input  logic rst,
  bus_if.slave sm,
  bus_if.slave ld,
  bus_if.master mem,
  output logic bus_busy
);

  // current bus owner
  typedef enum logic [1:0] {
    own_none,
    own_load,
    own_fetch
  } owner_t;

  owner_t owner;

  logic ld_req;
  logic sm_req;
  logic mem_dn;

  assign ld_req = ld.read_q | ld.write_q;
  assign sm_req = sm.read_q | sm.write_q;
  assign mem_dn = mem.read_dn | mem.write_dn;

  assign bus_busy = (owner != own_none);

  // grant only from none with load first
  // release on the memory done pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      owner <= own_none;
    end else if (owner == own_none) begin
      if (ld_req) begin
        owner <= own_load;
      end else if (sm_req) begin
        owner <= own_fetch;
      end
    end else if (mem_dn) begin
      owner <= own_none;
    end
  end

  // request forward and response steering
  // the master without the grant sees nothing
  always_comb begin
    mem.addr     = '0;
    mem.wdata    = '0;
    mem.read_q   = 1'b0;
    mem.write_q  = 1'b0;
    sm.rdata     = '0;
    sm.read_dn   = 1'b0;
    sm.write_dn  = 1'b0;
    ld.rdata     = '0;
    ld.read_dn   = 1'b0;
    ld.write_dn  = 1'b0;
    case (owner)
      own_load: begin
        mem.addr    = ld.addr;
        mem.wdata   = ld.wdata;
        mem.read_q  = ld.read_q;
        mem.write_q = ld.write_q;
        ld.rdata    = mem.rdata;
        ld.read_dn  = mem.read_dn;
        ld.write_dn = mem.write_dn;
      end
      own_fetch: begin
        mem.addr    = sm.addr;
        mem.wdata   = sm.wdata;
        mem.read_q  = sm.read_q;
        mem.write_q = sm.write_q;
        sm.rdata    = mem.rdata;
        sm.read_dn  = mem.read_dn;
        sm.write_dn = mem.write_dn;
      end
      default: begin
      end
    endcase
  end

endmodule

//--- word_memory.sv
`timescale 1ns/100ps

module word_memory (
  input logic  clk,
  bus_if.slave bus
);

  start_pkg::data_t mem [start_pkg::MEM_DEPTH];

  logic rd_new;
  logic wr_new;

  // a request counts once
  // the cycle its done pulse is out it is not served again
  assign rd_new = bus.read_q & ~bus.read_dn;
  assign wr_new = bus.write_q & ~bus.write_dn;

  // one-cycle done pulses
  always_ff @(posedge clk) begin
    bus.read_dn  <= rd_new;
    bus.write_dn <= wr_new;
  end

  // word array, address wraps at the depth
  always_ff @(posedge clk) begin
    if (wr_new) begin
      mem[bus.addr % start_pkg::MEM_DEPTH] <= bus.wdata;
    end
  end

  // registered read data
  // valid with read_dn
  always_ff @(posedge clk) begin
    if (rd_new) begin
      bus.rdata <= mem[bus.addr % start_pkg::MEM_DEPTH];
    end
  end

endmodule

//--- start_unit.sv
`timescale 1ns/100ps

module start_unit (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  logic             disp_online,
  input  start_pkg::addr_t base_addr,
  input  logic             load_we,
  input  start_pkg::addr_t load_addr,
  input  start_pkg::data_t load_data,
  output logic             load_ready,
  output start_pkg::data_t command,
  output start_pkg::addr_t cmd_ptr,
  output logic             done,
  output logic             bus_busy
);

  // fetch side
  bus_if sm_bus ();
  // load side
  bus_if ld_bus ();
  // arbiter to memory
  bus_if mem_bus ();

  start_manager u_start_manager (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .disp_online (disp_online),
    .base_addr   (base_addr),
    .bus         (sm_bus.master),
    .command     (command),
    .cmd_ptr     (cmd_ptr),
    .done        (done)
  );

  load_port u_load_port (
    .clk        (clk),
    .rst        (rst),
    .load_we    (load_we),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .load_ready (load_ready),
    .bus        (ld_bus.master)
  );

  bus_arbiter u_bus_arbiter (
    .clk      (clk),
    .rst      (rst),
    .sm       (sm_bus.slave),
    .ld       (ld_bus.slave),
    .mem      (mem_bus.master),
    .bus_busy (bus_busy)
  );

  word_memory u_word_memory (
    .clk (clk),
    .bus (mem_bus.slave)
  );

endmodule

//--- start_unit_assertions.sv
`timescale 1ns/100ps

// protocol checks bound into start_unit
// bus index 0 is sm_bus, 1 is ld_bus, 2 is mem_bus
module start_unit_assertions (
  input logic       clk,
  input logic       rst,
  input logic       done,
  input logic       bus_busy,
  input logic [2:0] read_q,
  input logic [2:0] write_q,
  input logic [2:0] read_dn,
  input logic [2:0] write_dn
);

  // failed assertions so far
  int fail_count = 0;

  logic both_req;

  // load and fetch asking at once while the arbiter is idle
  assign both_req = !bus_busy && (read_q[1] || write_q[1]) && (read_q[0] || write_q[0]);

  done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else begin
      fail_count++;
      $error("done held longer than one cycle");
    end

  // never a read and a write on the same bus
  one_request: assert property (@(posedge clk) disable iff (rst) (read_q & write_q) == 3'b000)
    else begin
      fail_count++;
      $error("read_q and write_q high together");
    end

  // a done pulse always answers a raised request
  dn_with_req: assert property (@(posedge clk) disable iff (rst)
    ((read_dn & ~read_q) | (write_dn & ~write_q)) == 3'b000)
    else begin
      fail_count++;
      $error("done pulse without a request");
    end

  // grant at the next edge and the memory answer one cycle later
  // only the load gets that answer
  load_first: assert property (@(posedge clk) disable iff (rst)
    both_req |-> ##2 (write_dn[1] && !read_dn[0] && !write_dn[0]))
    else begin
      fail_count++;
      $error("fetch served before a simultaneous load");
    end

endmodule

//--- tb_start_unit.sv
`timescale 1ns/100ps

module tb_start_unit;

  // cycles any single wait may take
  localparam int TIMEOUT = 100;
  // window in which a gated start must stay silent
  localparam int GATE_CYCLES = 50;

  logic             clk = 1'b0;
  logic             rst = 1'b1;
  logic             start = 1'b0;
  logic             disp_online = 1'b1;
  start_pkg::addr_t base_addr = 16'h0040;
  logic             load_we = 1'b0;
  start_pkg::addr_t load_addr = '0;
  start_pkg::data_t load_data = '0;
  logic             load_ready;
  start_pkg::data_t command;
  start_pkg::addr_t cmd_ptr;
  logic             done;
  logic             bus_busy;

  // copy of every word written through the load port
  start_pkg::data_t mirror [start_pkg::MEM_DEPTH];
  int errors = 0;
  int seed = 74462;

  always #5 clk = ~clk;

  start_unit uut (.*);

  bind start_unit start_unit_assertions u_assertions (
    .clk      (clk),
    .rst      (rst),
    .done     (done),
    .bus_busy (bus_busy),
    .read_q   ({mem_bus.read_q, ld_bus.read_q, sm_bus.read_q}),
    .write_q  ({mem_bus.write_q, ld_bus.write_q, sm_bus.write_q}),
    .read_dn  ({mem_bus.read_dn, ld_bus.read_dn, sm_bus.read_dn}),
    .write_dn ({mem_bus.write_dn, ld_bus.write_dn, sm_bus.write_dn})
  );

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp)
    else begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // one strobe once the port is free
  task automatic load_word(input start_pkg::addr_t addr, input start_pkg::data_t data);
    int n;
    n = 0;
    while (!load_ready && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!load_ready) begin
      errors++;
      $display("load port never became ready for address %h", addr);
    end else begin
      load_we   = 1'b1;
      load_addr = addr;
      load_data = data;
      @(posedge clk);
      #1;
      load_we = 1'b0;
      mirror[addr % start_pkg::MEM_DEPTH] = data;
    end
  endtask

  task automatic pulse_start();
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  // expected values from the mirror
  // the write-back is folded into the mirror
  task automatic fetch_check(input string name);
    start_pkg::addr_t ip_addr;
    start_pkg::addr_t ptr;
    start_pkg::addr_t next_ptr;
    start_pkg::data_t exp_cmd;
    int n;
    ip_addr  = base_addr + start_pkg::REG_IP;
    ptr      = start_pkg::addr_t'(mirror[ip_addr % start_pkg::MEM_DEPTH]);
    next_ptr = ptr + 16'd1;
    exp_cmd  = mirror[ptr % start_pkg::MEM_DEPTH];
    n = 0;
    while (!done && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!done) begin
      errors++;
      $display("%s: done never came", name);
    end else begin
      check_value({name, " command"}, exp_cmd, command);
      check_value({name, " cmd_ptr"}, next_ptr, cmd_ptr);
      mirror[ip_addr % start_pkg::MEM_DEPTH] = next_ptr;
    end
    // step out of the finish state
    @(posedge clk);
    #1;
  endtask

  // only load_ready high in the lowest bit
  task automatic check_idle(input string name);
    check_value({name, " idle levels"}, 32'h1,
      {done, bus_busy, uut.sm_bus.read_q, uut.sm_bus.write_q, uut.ld_bus.write_q,
       uut.mem_bus.read_q, uut.mem_bus.write_q, load_ready});
  endtask

  task automatic reset_dut();
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
  endtask

  initial begin
    logic quiet;
    reset_dut();
    check_idle("reset");
    // pointer register, then a block of commands
    load_word(base_addr + start_pkg::REG_IP, 32'h0000_0080);
    for (int i = 0; i < 8; i++) begin
      load_word(16'h0080 + start_pkg::addr_t'(i), $random(seed));
    end
    pulse_start();
    fetch_check("fetch");
    // no reload, so the pointer must come from memory
    pulse_start();
    fetch_check("write_back");
    disp_online = 1'b0;
    pulse_start();
    quiet = 1'b1;
    for (int i = 0; i < GATE_CYCLES; i++) begin
      @(posedge clk);
      #1;
      if (bus_busy || done) begin
        quiet = 1'b0;
      end
    end
    check_value("gating quiet", 32'h1, quiet);
    disp_online = 1'b1;
    fetch_check("gating");
    // load hits the command address while the fetch asks
    pulse_start();
    load_word(start_pkg::addr_t'(mirror[(base_addr + start_pkg::REG_IP) %
              start_pkg::MEM_DEPTH]), $random(seed));
    fetch_check("contention");
    // reset with the pointer read pending
    pulse_start();
    @(posedge clk);
    #1;
    reset_dut();
    check_idle("mid reset");
    pulse_start();
    fetch_check("restart");
    $display("errors: %0d checks, %0d assertions", errors, uut.u_assertions.fail_count);
    if (errors + uut.u_assertions.fail_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- compile.f
start_pkg.sv
bus_if.sv
start_manager.sv
load_port.sv
bus_arbiter.sv
word_memory.sv
start_unit.sv
start_unit_assertions.sv
tb_start_unit.sv

//--- Bender.yml
package:
  name: start_unit

sources:
  - files:
      - start_pkg.sv
      - bus_if.sv
      - start_manager.sv
      - load_port.sv
      - bus_arbiter.sv
      - word_memory.sv
      - start_unit.sv
  - target: test
    files:
      - start_unit_assertions.sv
      - tb_start_unit.sv
